//--- dv/qerv_properties.sv
`timescale 1ns/1ps

module qerv_properties
   import qerv_isa_pkg::*;
(
   input logic  clk,
   input logic  i_arst_n,
   input logic  i_ibus_cyc,
   input word_t i_ibus_adr,
   input logic  i_ibus_ack,
   input logic  i_dbus_cyc,
   input word_t i_dbus_adr,
   input word_t i_dbus_dat,
   input logic  i_dbus_ack
);

   // Failure tally, summed into the testbench error count
   int n_fail = 0;

   a_one_bus_at_a_time: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else begin
         $error("ibus and dbus cycles are high together");
         n_fail++;
      end

   a_ibus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_ibus_cyc && !i_ibus_ack) |=> (i_ibus_cyc && $stable(i_ibus_adr)))
      else begin
         $error("ibus cycle or address changed before ack");
         n_fail++;
      end

   a_dbus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_dbus_cyc && !i_dbus_ack) |=>
      (i_dbus_cyc && $stable(i_dbus_adr) && $stable(i_dbus_dat)))
      else begin
         $error("dbus cycle, address or data changed before ack");
         n_fail++;
      end

   a_idle_in_reset: assert property (@(posedge clk)
      !i_arst_n |-> (!i_ibus_cyc && !i_dbus_cyc))
      else begin
         $error("bus cycle high during reset");
         n_fail++;
      end

endmodule

bind qerv_top qerv_properties u_qerv_properties (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat),
   .i_dbus_ack (i_dbus_ack)
);

//--- dv/qerv_tb.sv
`timescale 1ns/1ps

module qerv_tb
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
();

   // 71 instructions issued over all tests
   localparam int N_INSTR        = 71;
   localparam int TIMEOUT_CYCLES = 40 * N_INSTR;

   logic  clk;
   logic  i_arst_n;
   word_t i_ibus_rdt;
   logic  i_ibus_ack;
   logic  i_dbus_ack;
   logic  o_ibus_cyc;
   word_t o_ibus_adr;
   logic  o_dbus_cyc;
   word_t o_dbus_adr;
   word_t o_dbus_dat;

   word_t       rf_model [32];
   word_t       pc_model;
   logic [15:0] lfsr_q;
   logic        dbus_cyc_q = 1'b0;
   int          n_checks = 0;
   int          n_errors = 0;
   int          n_total = 0;
   int          n_issued = 0;
   int          stores_expected = 0;
   int          stores_seen = 0;
   int          cycles = 0;

   tb_clkgen u_clkgen (
      .o_clk (clk)
   );

   qerv_top u_qerv_top (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_dbus_cyc (o_dbus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

   // Taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t sext13(input logic [12:0] v);
      return {{19{v[12]}}, v};
   endfunction

   // Expected results from the RV32I rules
   function automatic word_t alu_rule(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
      case (f3)
         F3_ADD_SUB: return sub ? a - b : a + b;
         F3_XOR:     return a ^ b;
         F3_OR:      return a | b;
         F3_AND:     return a & b;
         default:    return '0;
      endcase
   endfunction

   function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OP};
   endfunction

   function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
   endfunction

   function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, LUI};
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_data(input string name, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_adr(input string name, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic flag_error(input string what);
      n_errors++;
      $display("ERROR %s", what);
   endtask

   // One LFSR step per bit
   task automatic draw(input int n_bits, output word_t value);
      value = '0;
      for (int i = 0; i < n_bits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         value  = {value[XLEN-2:0], lfsr_q[0]};
      end
   endtask

   task automatic fetch_instr(input word_t instr);
      word_t gap;
      while (!o_ibus_cyc) begin
         step();
      end
      check_adr("o_ibus_adr", o_ibus_adr, pc_model);
      draw(2, gap);
      repeat (int'(gap)) begin
         step();
      end
      i_ibus_rdt = instr;
      i_ibus_ack = 1'b1;
      step();
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      n_issued++;
   endtask

   task automatic issue(input word_t instr);
      fetch_instr(instr);
      pc_model = pc_model + word_t'(4);
   endtask

   task automatic write_model(input reg_addr_t rd, input word_t value);
      if (rd != '0) begin
         rf_model[rd] = value;
      end
   endtask

   task automatic alu_reg_op(input logic [2:0] f3, input logic sub, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2);
      issue(r_type(sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd));
      write_model(rd, alu_rule(f3, sub, rf_model[rs1], rf_model[rs2]));
   endtask

   task automatic alu_imm_op(input logic [2:0] f3, input reg_addr_t rd,
                             input reg_addr_t rs1, input logic [11:0] imm);
      issue(i_type(imm, rs1, f3, rd, OP_IMM));
      write_model(rd, alu_rule(f3, 1'b0, rf_model[rs1], sext12(imm)));
   endtask

   task automatic load_upper(input reg_addr_t rd, input logic [19:0] imm);
      issue(u_type(imm, rd));
      write_model(rd, {imm, 12'b0});
   endtask

   // Upper part rounded so that the signed low part lands on value
   task automatic load_reg(input reg_addr_t rd, input word_t value);
      logic [19:0] upper;
      upper = value[31:12] + 20'(value[11]);
      load_upper(rd, upper);
      alu_imm_op(F3_ADD_SUB, rd, rd, value[11:0]);
   endtask

   task automatic serve_store(input word_t exp_adr, input word_t exp_dat,
                              input logic long_wait);
      word_t gap;
      stores_expected++;
      while (!o_dbus_cyc) begin
         step();
      end
      check_adr("o_dbus_adr", o_dbus_adr, exp_adr);
      check_data("o_dbus_dat", o_dbus_dat, exp_dat);
      draw(long_wait ? 3 : 2, gap);
      if (long_wait) begin
         gap = gap + word_t'(12);
      end
      repeat (int'(gap)) begin
         if (o_ibus_cyc) begin
            flag_error("Instruction fetch started while a store was waiting for ack");
         end
         step();
      end
      check_data("o_dbus_dat", o_dbus_dat, exp_dat);
      i_dbus_ack = 1'b1;
      step();
      i_dbus_ack = 1'b0;
      if (o_dbus_cyc) begin
         flag_error("Data bus cycle still high after ack");
      end
   endtask

   task automatic store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                             input logic [11:0] off, input logic long_wait);
      word_t exp_adr;
      exp_adr = rf_model[rs1] + sext12(off);
      issue(s_type(off, rs2, rs1, F3_SW));
      serve_store(exp_adr, rf_model[rs2], long_wait);
   endtask

   task automatic branch_to(input logic [2:0] f3, input reg_addr_t rs1,
                            input reg_addr_t rs2, input logic [12:0] off);
      logic taken;
      taken = (rf_model[rs1] == rf_model[rs2]) ^ (f3 == F3_BNE);
      fetch_instr(b_type(off, rs2, rs1, f3));
      pc_model = pc_model + (taken ? sext13(off) : word_t'(4));
   endtask

   task automatic fetch_order();
      step();
      if (!o_ibus_cyc) begin
         flag_error("No instruction fetch in the cycle after reset release");
      end
      alu_imm_op(F3_ADD_SUB, 5'd1, 5'd0, 12'h123);
      alu_imm_op(F3_ADD_SUB, 5'd2, 5'd1, 12'h7ff);
      store_word(5'd2, 5'd0, 12'h040, 1'b0);
   endtask

   task automatic immediates_and_lui();
      word_t a;
      word_t b;
      word_t u;
      word_t off;
      for (int k = 0; k < 2; k++) begin
         draw(12, a);
         draw(12, b);
         draw(20, u);
         draw(12, off);
         alu_imm_op(F3_ADD_SUB, 5'd8, 5'd0, a[11:0]);
         store_word(5'd8, 5'd0, off[11:0], 1'b0);
         load_upper(5'd9, u[19:0]);
         store_word(5'd9, 5'd0, off[11:0] + 12'd4, 1'b0);
         alu_imm_op(F3_XOR, 5'd10, 5'd8, b[11:0]);
         alu_imm_op(F3_OR, 5'd11, 5'd8, b[11:0]);
         alu_imm_op(F3_AND, 5'd12, 5'd8, b[11:0]);
         store_word(5'd10, 5'd0, off[11:0] + 12'd8, 1'b0);
         store_word(5'd11, 5'd0, off[11:0] + 12'd12, 1'b0);
         store_word(5'd12, 5'd0, off[11:0] + 12'd16, 1'b0);
      end
   endtask

   task automatic register_ops();
      word_t a;
      word_t b;
      for (int k = 0; k < 2; k++) begin
         draw(32, a);
         draw(32, b);
         load_reg(5'd1, a);
         load_reg(5'd2, b);
         alu_reg_op(F3_ADD_SUB, 1'b0, 5'd3, 5'd1, 5'd2);
         alu_reg_op(F3_ADD_SUB, 1'b1, 5'd4, 5'd1, 5'd2);
         alu_reg_op(F3_AND, 1'b0, 5'd5, 5'd1, 5'd2);
         alu_reg_op(F3_OR, 1'b0, 5'd6, 5'd1, 5'd2);
         alu_reg_op(F3_XOR, 1'b0, 5'd7, 5'd1, 5'd2);
         for (int r = 3; r <= 7; r++) begin
            store_word(reg_addr_t'(r), 5'd0, 12'(12'h100 + 32 * k + 4 * r), 1'b0);
         end
      end
   endtask

   task automatic x0_and_unsupported();
      alu_imm_op(F3_ADD_SUB, 5'd0, 5'd1, 12'h555);
      alu_reg_op(F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 5'd2);
      store_word(5'd0, 5'd0, 12'h200, 1'b0);
      // LW, SLT and an unused opcode all fall through as no-ops
      issue(i_type(12'h000, 5'd1, 3'b010, 5'd5, 7'b0000011));
      issue(r_type(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd6));
      issue(32'hffff_ffff);
      store_word(5'd5, 5'd0, 12'h204, 1'b0);
      store_word(5'd6, 5'd0, 12'h208, 1'b0);
   endtask

   task automatic branches();
      alu_imm_op(F3_ADD_SUB, 5'd2, 5'd1, 12'h000);
      // x3 differs from x1 in nibble 0 only
      alu_imm_op(F3_XOR, 5'd3, 5'd1, 12'h001);
      branch_to(F3_BEQ, 5'd1, 5'd2, 13'd8);
      branch_to(F3_BEQ, 5'd1, 5'd3, 13'd64);
      branch_to(F3_BNE, 5'd1, 5'd3, 13'd12);
      branch_to(F3_BNE, 5'd1, 5'd2, 13'd16);
      branch_to(F3_BEQ, 5'd0, 5'd0, 13'h1fec);
      store_word(5'd3, 5'd2, 12'hffc, 1'b0);
   endtask

   task automatic slow_stores();
      store_word(5'd1, 5'd0, 12'h300, 1'b1);
      store_word(5'd2, 5'd2, 12'h010, 1'b1);
      store_word(5'd3, 5'd0, 12'h308, 1'b1);
      store_word(5'd4, 5'd1, 12'h7f0, 1'b1);
   endtask

   // Counts every data bus cycle the core starts
   always @(negedge clk) begin
      if (o_dbus_cyc && !dbus_cyc_q) begin
         stores_seen++;
      end
      dbus_cyc_q = o_dbus_cyc;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: no finish after %0d cycles, %0d errors so far", cycles, n_errors);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      i_arst_n   = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      pc_model   = RESET_PC;
      lfsr_q     = 16'd2;
      for (int i = 0; i < 32; i++) begin
         rf_model[i] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      if (o_ibus_cyc || o_dbus_cyc) begin
         flag_error("Bus cycle active during reset");
      end
      i_arst_n = 1'b1;

      fetch_order();
      immediates_and_lui();
      register_ops();
      x0_and_unsupported();
      branches();
      slow_stores();

      // Last instruction must still advance the PC
      while (!o_ibus_cyc) begin
         step();
      end
      check_adr("o_ibus_adr", o_ibus_adr, pc_model);
      if (stores_seen != stores_expected) begin
         flag_error($sformatf("Saw %0d data bus cycles for %0d SW instructions",
                              stores_seen, stores_expected));
      end

      n_total = n_errors + u_qerv_top.u_qerv_properties.n_fail;
      $display("Summary: %0d instructions, %0d checks, %0d errors, %0d assertion failures",
               n_issued, n_checks, n_errors, u_qerv_top.u_qerv_properties.n_fail);
      if (n_total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
   output logic o_clk
);

   // 8 ns period
   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

endmodule

//--- rtl/qerv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_alu
   import qerv_core_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  logic    i_exec_en,
   input  cnt_t    i_cnt,
   input  decode_t i_ctrl,
   input  nibble_t i_rs1,
   input  nibble_t i_rs2,
   output nibble_t o_result,
   output logic    o_branch_taken
);

   nibble_t    op_b;
   nibble_t    op_b_add;
   logic       is_sub;
   logic       first;
   logic       carry_in;
   logic       carry_q;
   logic       eq_in;
   logic       eq_q;
   logic       eq_now;
   logic [W:0] sum;

   assign first = (i_cnt == '0);
   assign op_b  = i_ctrl.op_b_imm ? i_ctrl.imm[i_cnt*W +: W] : i_rs2;

   // Subtract as rs1 + ~b + 1, the +1 enters on step 0
   assign is_sub   = (i_ctrl.alu_op == SUB);
   assign op_b_add = is_sub ? ~op_b : op_b;
   assign carry_in = first ? is_sub : carry_q;
   assign sum      = {1'b0, i_rs1} + {1'b0, op_b_add} + {{W{1'b0}}, carry_in};

   assign eq_in  = first ? 1'b1 : eq_q;
   assign eq_now = eq_in & (i_rs1 == i_rs2);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_exec_en) begin
         carry_q <= sum[W];
         eq_q    <= eq_now;
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ADD, SUB: o_result = sum[W-1:0];
         AND:      o_result = i_rs1 & op_b;
         OR:       o_result = i_rs1 | op_b;
         XOR:      o_result = i_rs1 ^ op_b;
         PASS_IMM: o_result = op_b;
         default:  o_result = '0;
      endcase
   end

   // Only meaningful on the last step
   assign o_branch_taken = i_ctrl.is_branch & (eq_now ^ i_ctrl.branch_ne);

endmodule

`default_nettype wire

//--- rtl/qerv_core_pkg.sv
package qerv_core_pkg;

   import qerv_isa_pkg::*;

   // Nibble-serial datapath
   localparam int W       = 4;
   localparam int NIBBLES = XLEN / W;

   localparam word_t RESET_PC = '0;

   typedef logic [W-1:0] nibble_t;
   typedef logic [2:0]   cnt_t;
   typedef logic [4:0]   reg_addr_t;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      PASS_IMM
   } alu_op_e;

   typedef enum logic [1:0] {
      S_FETCH,
      S_DECODE,
      S_EXEC,
      S_STORE
   } core_state_e;

   // Control held from decode until the next instruction
   typedef struct packed {
      alu_op_e   alu_op;
      logic      op_b_imm;
      logic      rd_en;
      logic      is_branch;
      logic      branch_ne;
      logic      is_store;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     imm;
   } decode_t;

endpackage

//--- rtl/qerv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_decode
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  word_t   i_instr,
   input  logic    i_instr_valid,
   output decode_t o_ctrl
);

   decode_t    ctrl_d;
   logic [2:0] funct3;

   assign funct3 = i_instr[14:12];

   always_comb begin
      ctrl_d     = '0;
      ctrl_d.rd  = i_instr[11:7];
      ctrl_d.rs1 = i_instr[19:15];
      ctrl_d.rs2 = i_instr[24:20];
      case (opcode_e'(i_instr[6:0]))
         OP: begin
            ctrl_d.rd_en = 1'b1;
            case (funct3)
               F3_ADD_SUB: ctrl_d.alu_op = i_instr[30] ? SUB : ADD;
               F3_XOR:     ctrl_d.alu_op = XOR;
               F3_OR:      ctrl_d.alu_op = OR;
               F3_AND:     ctrl_d.alu_op = AND;
               default:    ctrl_d.rd_en  = 1'b0;
            endcase
         end
         OP_IMM: begin
            ctrl_d.rd_en    = 1'b1;
            ctrl_d.op_b_imm = 1'b1;
            ctrl_d.imm      = {{20{i_instr[31]}}, i_instr[31:20]};
            case (funct3)
               F3_ADD_SUB: ctrl_d.alu_op = ADD;
               F3_XOR:     ctrl_d.alu_op = XOR;
               F3_OR:      ctrl_d.alu_op = OR;
               F3_AND:     ctrl_d.alu_op = AND;
               default:    ctrl_d.rd_en  = 1'b0;
            endcase
         end
         LUI: begin
            ctrl_d.rd_en    = 1'b1;
            ctrl_d.op_b_imm = 1'b1;
            ctrl_d.alu_op   = PASS_IMM;
            ctrl_d.imm      = {i_instr[31:12], 12'b0};
         end
         BRANCH: begin
            ctrl_d.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            ctrl_d.branch_ne = (funct3 == F3_BNE);
            ctrl_d.alu_op    = SUB;
            ctrl_d.imm       = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                i_instr[30:25], i_instr[11:8], 1'b0};
         end
         STORE: begin
            // Address is rs1 plus offset through the adder
            ctrl_d.is_store = (funct3 == F3_SW);
            ctrl_d.op_b_imm = 1'b1;
            ctrl_d.alu_op   = ADD;
            ctrl_d.imm      = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         end
         default: ;
      endcase
      if (ctrl_d.rd == '0) begin
         ctrl_d.rd_en = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ctrl <= '0;
      end else if (i_instr_valid) begin
         o_ctrl <= ctrl_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/qerv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_fetch
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
(
   input  logic  clk,
   input  logic  i_arst_n,
   input  logic  i_fetch_en,
   input  logic  i_pc_update,
   input  logic  i_branch_taken,
   input  word_t i_imm,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   output logic  o_ibus_cyc,
   output word_t o_ibus_adr,
   output word_t o_instr,
   output logic  o_instr_valid
);

   word_t pc;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc            <= RESET_PC;
         o_ibus_cyc    <= 1'b0;
         o_instr_valid <= 1'b0;
      end else begin
         // Bus cycle ends on ack, next one waits for a new fetch phase
         if (o_ibus_cyc && i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end else if (i_fetch_en) begin
            o_ibus_cyc <= 1'b1;
         end
         o_instr_valid <= o_ibus_cyc & i_ibus_ack;
         if (i_pc_update) begin
            pc <= pc + (i_branch_taken ? i_imm : word_t'(4));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (o_ibus_cyc && i_ibus_ack) begin
         o_instr <= i_ibus_rdt;
      end
   end

   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

//--- rtl/qerv_isa_pkg.sv
package qerv_isa_pkg;

   // Register and address width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      BRANCH = 7'b1100011,
      STORE  = 7'b0100011
   } opcode_e;

   // ALU group
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Branch group
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

   // Store group, word only
   localparam logic [2:0] F3_SW = 3'b010;

endpackage

//--- rtl/qerv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_regfile
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
(
   input  logic      clk,
   input  logic      i_arst_n,
   input  cnt_t      i_cnt,
   input  logic      i_wen,
   input  reg_addr_t i_rd,
   input  reg_addr_t i_rs1,
   input  reg_addr_t i_rs2,
   input  nibble_t   i_wdata,
   output nibble_t   o_rs1,
   output nibble_t   o_rs2
);

   localparam int NREGS = 2 ** $bits(reg_addr_t);

   word_t regs [NREGS];

   // One nibble per step, x0 is never written
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && (i_rd != '0)) begin
         regs[i_rd][i_cnt*W +: W] <= i_wdata;
      end
   end

   assign o_rs1 = (i_rs1 == '0) ? '0 : regs[i_rs1][i_cnt*W +: W];
   assign o_rs2 = (i_rs2 == '0) ? '0 : regs[i_rs2][i_cnt*W +: W];

endmodule

`default_nettype wire

//--- rtl/qerv_state.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_state
   import qerv_core_pkg::*;
(
   input  logic        clk,
   input  logic        i_arst_n,
   input  logic        i_ibus_ack,
   input  logic        i_dbus_ack,
   input  logic        i_is_store,
   output core_state_e o_state,
   output cnt_t        o_cnt,
   output logic        o_exec_en,
   output logic        o_last,
   output logic        o_pc_update,
   output logic        o_store_start
);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_state <= S_FETCH;
         o_cnt   <= '0;
      end else begin
         case (o_state)
            S_FETCH: begin
               if (i_ibus_ack) begin
                  o_state <= S_DECODE;
               end
            end
            S_DECODE: o_state <= S_EXEC;
            S_EXEC: begin
               // Counter wraps back to 0 after the last nibble
               o_cnt <= o_cnt + cnt_t'(1);
               if (o_last) begin
                  o_state <= i_is_store ? S_STORE : S_FETCH;
               end
            end
            S_STORE: begin
               if (i_dbus_ack) begin
                  o_state <= S_FETCH;
               end
            end
            default: o_state <= S_FETCH;
         endcase
      end
   end

   assign o_exec_en     = (o_state == S_EXEC);
   assign o_last        = o_exec_en && (o_cnt == cnt_t'(NIBBLES - 1));
   assign o_pc_update   = o_last;
   assign o_store_start = o_last & i_is_store;

endmodule

`default_nettype wire

//--- rtl/qerv_store.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_store
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  logic    i_exec_en,
   input  logic    i_is_store,
   input  logic    i_store_start,
   input  nibble_t i_addr_nib,
   input  nibble_t i_data_nib,
   input  logic    i_dbus_ack,
   output logic    o_dbus_cyc,
   output word_t   o_dbus_adr,
   output word_t   o_dbus_dat
);

   // LSB nibble first, so after 8 shifts nibble 0 sits at the bottom
   always_ff @(posedge clk) begin
      if (i_exec_en && i_is_store) begin
         o_dbus_adr <= {i_addr_nib, o_dbus_adr[XLEN-1:W]};
         o_dbus_dat <= {i_data_nib, o_dbus_dat[XLEN-1:W]};
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_dbus_cyc <= 1'b0;
      end else if (o_dbus_cyc && i_dbus_ack) begin
         o_dbus_cyc <= 1'b0;
      end else if (i_store_start) begin
         o_dbus_cyc <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/qerv_top.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_top
   import qerv_isa_pkg::*;
   import qerv_core_pkg::*;
(
   input  logic  clk,
   input  logic  i_arst_n,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   input  logic  i_dbus_ack,
   output logic  o_ibus_cyc,
   output word_t o_ibus_adr,
   output logic  o_dbus_cyc,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat
);

   core_state_e state;
   cnt_t        cnt;
   logic        exec_en;
   logic        pc_update;
   logic        store_start;
   logic        fetch_en;
   word_t       instr;
   logic        instr_valid;
   decode_t     ctrl;
   nibble_t     rs1;
   nibble_t     rs2;
   nibble_t     result;
   logic        branch_taken;
   logic        rf_wen;

   assign fetch_en = (state == S_FETCH);
   assign rf_wen   = exec_en & ctrl.rd_en;

   // Input side
   qerv_fetch u_fetch (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_fetch_en     (fetch_en),
      .i_pc_update    (pc_update),
      .i_branch_taken (branch_taken),
      .i_imm          (ctrl.imm),
      .i_ibus_rdt     (i_ibus_rdt),
      .i_ibus_ack     (i_ibus_ack),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_ibus_adr     (o_ibus_adr),
      .o_instr        (instr),
      .o_instr_valid  (instr_valid)
   );

   qerv_decode u_decode (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_instr       (instr),
      .i_instr_valid (instr_valid),
      .o_ctrl        (ctrl)
   );

   // Processing
   qerv_state u_state (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_dbus_ack    (i_dbus_ack),
      .i_is_store    (ctrl.is_store),
      .o_state       (state),
      .o_cnt         (cnt),
      .o_exec_en     (exec_en),
      .o_last        (),
      .o_pc_update   (pc_update),
      .o_store_start (store_start)
   );

   qerv_regfile u_regfile (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cnt    (cnt),
      .i_wen    (rf_wen),
      .i_rd     (ctrl.rd),
      .i_rs1    (ctrl.rs1),
      .i_rs2    (ctrl.rs2),
      .i_wdata  (result),
      .o_rs1    (rs1),
      .o_rs2    (rs2)
   );

   qerv_alu u_alu (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_exec_en      (exec_en),
      .i_cnt          (cnt),
      .i_ctrl         (ctrl),
      .i_rs1          (rs1),
      .i_rs2          (rs2),
      .o_result       (result),
      .o_branch_taken (branch_taken)
   );

   // Output side
   qerv_store u_store (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_exec_en     (exec_en),
      .i_is_store    (ctrl.is_store),
      .i_store_start (store_start),
      .i_addr_nib    (result),
      .i_data_nib    (rs2),
      .i_dbus_ack    (i_dbus_ack),
      .o_dbus_cyc    (o_dbus_cyc),
      .o_dbus_adr    (o_dbus_adr),
      .o_dbus_dat    (o_dbus_dat)
   );

endmodule

`default_nettype wire

//--- src.f
rtl/qerv_isa_pkg.sv
rtl/qerv_core_pkg.sv
rtl/qerv_fetch.sv
rtl/qerv_decode.sv
rtl/qerv_state.sv
rtl/qerv_regfile.sv
rtl/qerv_alu.sv
rtl/qerv_store.sv
rtl/qerv_top.sv
dv/tb_clkgen.sv
dv/qerv_properties.sv
dv/qerv_tb.sv
